// File: hdl/uart_defines.svh
// UART register map and constants
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// register offsets
`define UART_ADDR_TDR   12'h000
`define UART_ADDR_RDR   12'h004
`define UART_ADDR_LCR   12'h008
`define UART_ADDR_LSR   12'h00C
`define UART_ADDR_IER   12'h010
`define UART_ADDR_IIR   12'h014

// sample ticks per bit
`define UART_OVERSAMPLE 16
// clocks per sample tick at baud select 0, doubled per step
`define UART_BASE_DIV   2

// 8 data bits, 1 stop, no parity, baud select 0, tx/rx disabled
`define UART_LCR_RESET  11'h003

`endif

// File: hdl/uart_cfg_pkg.sv
// UART line configuration types
`default_nettype none

package uart_cfg_pkg;

    // framing fields taken from LCR
    typedef struct packed {
        logic       parity_odd;
        logic       parity_en;
        logic       two_stop;
        // 0..3 means 5..8 bits
        logic [1:0] data_bits;
    } line_cfg_t;

    // LCR bits 10:9
    typedef struct packed {
        logic rx_en;
        logic tx_en;
    } ser_enable_t;

endpackage

`default_nettype wire

// File: hdl/uart_status_pkg.sv
// UART receive status and interrupt types
`default_nettype none

package uart_status_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       parity_err;
        logic       frame_err;
    } rx_char_t;

    typedef enum logic [2:0] {
        IIR_NONE     = 3'b001,
        IIR_LINE     = 3'b110,
        IIR_RX_READY = 3'b100,
        IIR_TX_EMPTY = 3'b010
    } iir_code_e;

endpackage

`default_nettype wire

// File: hdl/baud_tick_gen.sv
// UART baud tick generator
`timescale 1ns/100ps
`default_nettype none
`include "uart_defines.svh"

module baud_tick_gen (
    input  wire logic       clk,
    input  wire logic       preset_n,
    input  wire logic [2:0] baud_sel_i,
    output logic            sample_tick_o,
    output logic            bit_tick_o
);

    logic [8:0] divisor;
    logic [8:0] div_cnt_q;
    logic [3:0] os_cnt_q;
    logic [2:0] baud_sel_q;

    assign divisor = 9'(`UART_BASE_DIV) << baud_sel_i;

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            baud_sel_q    <= 3'd0;
            div_cnt_q     <= 9'd0;
            os_cnt_q      <= 4'd0;
            sample_tick_o <= 1'b0;
            bit_tick_o    <= 1'b0;
        end else if (baud_sel_i != baud_sel_q) begin
            // new rate, restart both counters
            baud_sel_q    <= baud_sel_i;
            div_cnt_q     <= 9'd0;
            os_cnt_q      <= 4'd0;
            sample_tick_o <= 1'b0;
            bit_tick_o    <= 1'b0;
        end else if (div_cnt_q == divisor - 9'd1) begin
            div_cnt_q     <= 9'd0;
            os_cnt_q      <= os_cnt_q + 4'd1;
            sample_tick_o <= 1'b1;
            bit_tick_o    <= (os_cnt_q == 4'(`UART_OVERSAMPLE - 1));
        end else begin
            div_cnt_q     <= div_cnt_q + 9'd1;
            sample_tick_o <= 1'b0;
            bit_tick_o    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_tx_fsm.sv
// UART transmitter
`timescale 1ns/100ps
`default_nettype none

module uart_tx_fsm
    import uart_cfg_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       preset_n,
    input  wire line_cfg_t  cfg_i,
    input  wire logic       bit_tick_i,
    input  wire logic       tx_start_i,
    input  wire logic [7:0] tx_data_i,
    output logic            tx_o,
    output logic            tx_busy_o
);

    typedef enum logic [2:0] {IDLE, WAIT, START, DATA, PARITY, STOP} tx_state_e;

    tx_state_e  state_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       par_q;
    logic [2:0] last_bit;

    assign last_bit = 3'(cfg_i.data_bits) + 3'd4;

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            state_q   <= IDLE;
            bit_cnt_q <= 3'd0;
            par_q     <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (tx_start_i) begin
                    par_q   <= 1'b0;
                    state_q <= WAIT;
                end
                // line stays idle until the next bit boundary
                WAIT: if (bit_tick_i) state_q <= START;
                START: if (bit_tick_i) begin
                    bit_cnt_q <= 3'd0;
                    state_q   <= DATA;
                end
                DATA: if (bit_tick_i) begin
                    par_q <= par_q ^ shift_q[0];
                    if (bit_cnt_q == last_bit) begin
                        bit_cnt_q <= 3'd0;
                        state_q   <= cfg_i.parity_en ? PARITY : STOP;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                    end
                end
                PARITY: if (bit_tick_i) state_q <= STOP;
                STOP: if (bit_tick_i) begin
                    if (cfg_i.two_stop && bit_cnt_q == 3'd0) bit_cnt_q <= 3'd1;
                    else state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // character shift register, lsb goes out first
    always_ff @(posedge clk) begin
        if (state_q == IDLE && tx_start_i) shift_q <= tx_data_i;
        else if (state_q == DATA && bit_tick_i) shift_q <= {1'b0, shift_q[7:1]};
    end

    always_comb begin
        case (state_q)
            START:   tx_o = 1'b0;
            DATA:    tx_o = shift_q[0];
            PARITY:  tx_o = par_q ^ cfg_i.parity_odd;
            default: tx_o = 1'b1;
        endcase
    end

    assign tx_busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

// File: hdl/uart_rx_shift.sv
// UART oversampling receiver
`timescale 1ns/100ps
`default_nettype none
`include "uart_defines.svh"

module uart_rx_shift
    import uart_cfg_pkg::*, uart_status_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      preset_n,
    input  wire line_cfg_t cfg_i,
    input  wire logic      rx_en_i,
    input  wire logic      sample_tick_i,
    input  wire logic      rx_i,
    output rx_char_t       rx_char_o
);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_e;

    rx_state_e  state_q;
    logic       rx_meta_q;
    logic       rx_sync_q;
    logic [3:0] smp_cnt_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic [7:0] data_q;
    logic       par_q;
    logic       perr_q;
    logic       ferr_q;
    logic       valid_q;
    logic [2:0] last_bit;
    logic       mid_bit;
    logic       frame_done;

    assign last_bit = 3'(cfg_i.data_bits) + 3'd4;

    // half a bit into the start bit, a full bit for the rest
    assign mid_bit = sample_tick_i && (smp_cnt_q == ((state_q == START) ?
                     4'(`UART_OVERSAMPLE / 2 - 1) : 4'(`UART_OVERSAMPLE - 1)));

    assign frame_done = mid_bit && state_q == STOP &&
                        !(cfg_i.two_stop && bit_cnt_q == 3'd0);

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            state_q   <= IDLE;
            smp_cnt_q <= 4'd0;
            bit_cnt_q <= 3'd0;
            par_q     <= 1'b0;
            perr_q    <= 1'b0;
            ferr_q    <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= frame_done;
            if (sample_tick_i) begin
                smp_cnt_q <= smp_cnt_q + 4'd1;
                case (state_q)
                    IDLE: begin
                        smp_cnt_q <= 4'd0;
                        if (rx_en_i && !rx_sync_q) state_q <= START;
                    end
                    START: if (mid_bit) begin
                        smp_cnt_q <= 4'd0;
                        bit_cnt_q <= 3'd0;
                        par_q     <= 1'b0;
                        perr_q    <= 1'b0;
                        ferr_q    <= 1'b0;
                        // high again at mid-bit means a glitch
                        state_q   <= rx_sync_q ? IDLE : DATA;
                    end
                    DATA: if (mid_bit) begin
                        par_q <= par_q ^ rx_sync_q;
                        if (bit_cnt_q == last_bit) begin
                            bit_cnt_q <= 3'd0;
                            state_q   <= cfg_i.parity_en ? PARITY : STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                        end
                    end
                    PARITY: if (mid_bit) begin
                        perr_q  <= rx_sync_q ^ par_q ^ cfg_i.parity_odd;
                        state_q <= STOP;
                    end
                    STOP: if (mid_bit) begin
                        if (!rx_sync_q) ferr_q <= 1'b1;
                        if (frame_done) state_q <= IDLE;
                        else bit_cnt_q <= 3'd1;
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mid_bit && state_q == DATA) shift_q <= {rx_sync_q, shift_q[7:1]};
        // short words sit in the top bits, move them down
        if (frame_done) data_q <= shift_q >> (2'd3 - cfg_i.data_bits);
    end

    assign rx_char_o.data       = data_q;
    assign rx_char_o.valid      = valid_q;
    assign rx_char_o.parity_err = perr_q;
    assign rx_char_o.frame_err  = ferr_q;

endmodule

`default_nettype wire

// File: hdl/apb_uart_regs.sv
// UART APB register file
`timescale 1ns/100ps
`default_nettype none
`include "uart_defines.svh"

module apb_uart_regs
    import uart_cfg_pkg::*, uart_status_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        preset_n,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [11:0] paddr_i,
    input  wire logic [31:0] pwdata_i,
    output logic      [31:0] prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    output line_cfg_t        cfg_o,
    output ser_enable_t      en_o,
    output logic      [2:0]  baud_sel_o,
    output logic      [7:0]  tx_data_o,
    output logic             tx_start_o,
    input  wire logic        tx_busy_i,
    input  wire rx_char_t    rx_char_i,
    output logic             irq_o
);

    logic [10:0] lcr_q;
    logic [2:0]  ier_q;
    logic [7:0]  tdr_q;
    logic [7:0]  rdr_q;
    logic        dr_q;
    logic        rx_ovr_q;
    logic        perr_q;
    logic        ferr_q;
    logic        tx_ovr_q;
    logic [5:0]  lsr;
    iir_code_e   iir_q;
    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic        rd_en;
    logic        tx_pending;
    logic        wr_tdr;
    logic        rd_lsr;
    logic        rd_rdr;
    logic        rx_valid;

    assign access  = psel_i && penable_i;
    assign addr_ok = paddr_i inside {`UART_ADDR_TDR, `UART_ADDR_RDR, `UART_ADDR_LCR,
                                     `UART_ADDR_LSR, `UART_ADDR_IER, `UART_ADDR_IIR};
    assign wr_en   = access && pwrite_i && addr_ok;
    assign rd_en   = access && !pwrite_i && addr_ok;

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !addr_ok;

    assign wr_tdr   = wr_en && paddr_i == `UART_ADDR_TDR;
    assign rd_lsr   = rd_en && paddr_i == `UART_ADDR_LSR;
    assign rd_rdr   = rd_en && paddr_i == `UART_ADDR_RDR;
    assign rx_valid = rx_char_i.valid;

    // a start already issued counts as busy
    assign tx_pending = tx_busy_i || tx_start_o;

    // LCR bit 3 is reserved
    assign cfg_o.data_bits  = lcr_q[1:0];
    assign cfg_o.two_stop   = lcr_q[2];
    assign cfg_o.parity_en  = lcr_q[4];
    assign cfg_o.parity_odd = lcr_q[5];
    assign baud_sel_o       = lcr_q[8:6];
    assign en_o             = ser_enable_t'(lcr_q[10:9]);
    assign tx_data_o        = tdr_q;

    assign lsr = {tx_ovr_q, !tx_busy_i, ferr_q, perr_q, rx_ovr_q, dr_q};

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            lcr_q      <= `UART_LCR_RESET;
            ier_q      <= 3'd0;
            tx_start_o <= 1'b0;
        end else begin
            tx_start_o <= wr_tdr && en_o.tx_en && !tx_pending;
            if (wr_en && paddr_i == `UART_ADDR_LCR) lcr_q <= pwdata_i[10:0];
            if (wr_en && paddr_i == `UART_ADDR_IER) ier_q <= pwdata_i[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tdr && !tx_pending) tdr_q <= pwdata_i[7:0];
        if (rx_valid) rdr_q <= rx_char_i.data;
    end

    // sticky status, a set in the same cycle as the clearing read wins
    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            dr_q     <= 1'b0;
            rx_ovr_q <= 1'b0;
            perr_q   <= 1'b0;
            ferr_q   <= 1'b0;
            tx_ovr_q <= 1'b0;
        end else begin
            if (rx_valid) dr_q <= 1'b1;
            else if (rd_rdr) dr_q <= 1'b0;

            if (rx_valid && dr_q) rx_ovr_q <= 1'b1;
            else if (rd_lsr) rx_ovr_q <= 1'b0;

            if (rx_valid && rx_char_i.parity_err) perr_q <= 1'b1;
            else if (rd_lsr) perr_q <= 1'b0;

            if (rx_valid && rx_char_i.frame_err) ferr_q <= 1'b1;
            else if (rd_lsr) ferr_q <= 1'b0;

            if (wr_tdr && tx_pending) tx_ovr_q <= 1'b1;
            else if (rd_lsr) tx_ovr_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            iir_q <= IIR_NONE;
        end else if (ier_q[2] && (lsr[1] || lsr[2] || lsr[3] || lsr[5])) begin
            iir_q <= IIR_LINE;
        end else if (ier_q[0] && lsr[0]) begin
            iir_q <= IIR_RX_READY;
        end else if (ier_q[1] && lsr[4]) begin
            iir_q <= IIR_TX_EMPTY;
        end else begin
            iir_q <= IIR_NONE;
        end
    end

    assign irq_o = (iir_q != IIR_NONE);

    always_comb begin
        case (paddr_i)
            `UART_ADDR_TDR: prdata_o = {24'd0, tdr_q};
            `UART_ADDR_RDR: prdata_o = {24'd0, rdr_q};
            `UART_ADDR_LCR: prdata_o = {21'd0, lcr_q};
            `UART_ADDR_LSR: prdata_o = {26'd0, lsr};
            `UART_ADDR_IER: prdata_o = {29'd0, ier_q};
            `UART_ADDR_IIR: prdata_o = {29'd0, iir_q};
            default:        prdata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/apb_uart.sv
// APB UART top level
`timescale 1ns/100ps
`default_nettype none

module apb_uart
    import uart_cfg_pkg::*, uart_status_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        preset_n,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [11:0] paddr_i,
    input  wire logic [31:0] pwdata_i,
    output logic      [31:0] prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    output logic             uart_tx_o,
    input  wire logic        uart_rx_i,
    output logic             irq_o
);

    line_cfg_t   cfg;
    ser_enable_t en;
    rx_char_t    rx_char;
    logic [2:0]  baud_sel;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic        tx_busy;
    logic        sample_tick;
    logic        bit_tick;

    apb_uart_regs u_regs (
        .clk        (clk),
        .preset_n   (preset_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .cfg_o      (cfg),
        .en_o       (en),
        .baud_sel_o (baud_sel),
        .tx_data_o  (tx_data),
        .tx_start_o (tx_start),
        .tx_busy_i  (tx_busy),
        .rx_char_i  (rx_char),
        .irq_o      (irq_o)
    );

    baud_tick_gen u_baud (
        .clk           (clk),
        .preset_n      (preset_n),
        .baud_sel_i    (baud_sel),
        .sample_tick_o (sample_tick),
        .bit_tick_o    (bit_tick)
    );

    uart_tx_fsm u_tx (
        .clk        (clk),
        .preset_n   (preset_n),
        .cfg_i      (cfg),
        .bit_tick_i (bit_tick),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .tx_o       (uart_tx_o),
        .tx_busy_o  (tx_busy)
    );

    uart_rx_shift u_rx (
        .clk           (clk),
        .preset_n      (preset_n),
        .cfg_i         (cfg),
        .rx_en_i       (en.rx_en),
        .sample_tick_i (sample_tick),
        .rx_i          (uart_rx_i),
        .rx_char_o     (rx_char)
    );

endmodule

`default_nettype wire

// File: tb/tb_apb_uart.sv
// APB UART testbench
`timescale 1ns/100ps
`default_nettype none
`include "uart_defines.svh"

module tb_apb_uart
    import uart_status_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int BIT_CLKS     = `UART_OVERSAMPLE * `UART_BASE_DIV;
    localparam int MAX_BIT_CLKS = BIT_CLKS * 8;
    localparam int FRAME_BITS   = 12;
    localparam int FRAME_COUNT  = 40;
    localparam int WATCHDOG_NS  = FRAME_COUNT * FRAME_BITS * MAX_BIT_CLKS * CLK_PERIOD * 2;
    localparam int POLL_LIMIT   = 2000;

    logic        clk;
    logic        preset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        uart_tx;
    logic        uart_rx;
    logic        irq;

    logic        last_slverr;
    logic [7:0]  lfsr_q = 8'd86;
    int          check_cnt;
    int          err_cnt;
    int          timeout_cnt;

    apb_uart dut_i (
        .clk       (clk),
        .preset_n  (preset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .uart_tx_o (uart_tx),
        .uart_rx_i (uart_rx),
        .irq_o     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
            err_cnt++;
        end
    endtask

    // galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic logic [31:0] lcr_word(input int db, input bit ts, input bit pe,
                                             input bit po, input int sel, input bit tx_en,
                                             input bit rx_en);
        lcr_word = {21'd0, rx_en, tx_en, 3'(sel), po, pe, 1'b0, ts, 2'(db)};
    endfunction

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        last_slverr = pslverr;
        check_val("apb write pready", 32'd1, {31'd0, pready});
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data        = prdata;
        last_slverr = pslverr;
        check_val("apb read pready", 32'd1, {31'd0, pready});
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_lsr(input logic [31:0] mask, input string name, output logic [31:0] v);
        int n;
        n = 0;
        v = 32'd0;
        while ((v & mask) == 32'd0 && n < POLL_LIMIT) begin
            apb_read(`UART_ADDR_LSR, v);
            n++;
        end
        if ((v & mask) == 32'd0) begin
            $display("timed out waiting for LSR bits 0x%0h in %s", mask, name);
            timeout_cnt++;
        end
    endtask

    task automatic wait_iir(input iir_code_e code, input string name);
        logic [31:0] v;
        int          n;
        n = 0;
        v = 32'd0;
        while (v[2:0] != code && n < POLL_LIMIT) begin
            apb_read(`UART_ADDR_IIR, v);
            n++;
        end
        if (v[2:0] != code) begin
            $display("timed out waiting for interrupt code %0d in %s", code, name);
            timeout_cnt++;
        end
    endtask

    task automatic hold_line(input logic level, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            uart_rx <= level;
        end
    endtask

    // drives one frame into the receiver and one idle bit after it
    task automatic send_frame(input logic [7:0] data, input int nbits, input bit pe, input bit po,
                              input bit ts, input bit bad_par, input bit bad_stop);
        logic par;
        par = po ? ~^data : ^data;
        hold_line(1'b0, BIT_CLKS);
        for (int i = 0; i < nbits; i++) hold_line(data[i], BIT_CLKS);
        if (pe) hold_line(par ^ bad_par, BIT_CLKS);
        if (bad_stop) begin
            hold_line(1'b0, BIT_CLKS * 3 / 4);
            hold_line(1'b1, BIT_CLKS - BIT_CLKS * 3 / 4);
        end else begin
            hold_line(1'b1, BIT_CLKS);
        end
        if (ts) hold_line(1'b1, BIT_CLKS);
        hold_line(1'b1, BIT_CLKS);
    endtask

    // samples uart_tx_o at mid-bit
    task automatic capture_frame(input int nbits, input bit pe, input bit ts, output bit found,
                                 output logic start_b, output logic [7:0] data,
                                 output logic par_b, output logic [1:0] stop_b);
        found   = 1'b0;
        start_b = 1'b1;
        data    = 8'h00;
        par_b   = 1'b0;
        stop_b  = 2'b11;
        for (int i = 0; i < 4 * BIT_CLKS && !found; i++) begin
            @(negedge clk);
            if (!uart_tx) found = 1'b1;
        end
        if (found) begin
            repeat (BIT_CLKS / 2) @(negedge clk);
            start_b = uart_tx;
            for (int i = 0; i < nbits; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[i] = uart_tx;
            end
            if (pe) begin
                repeat (BIT_CLKS) @(negedge clk);
                par_b = uart_tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            stop_b[0] = uart_tx;
            if (ts) begin
                repeat (BIT_CLKS) @(negedge clk);
                stop_b[1] = uart_tx;
            end
        end
    endtask

    task automatic test_reset_decode();
        logic [31:0] v;
        apb_read(`UART_ADDR_LSR, v);
        check_val("reset lsr", 32'h10, v);
        check_val("reset lsr slverr", 32'd0, {31'd0, last_slverr});
        apb_read(`UART_ADDR_IIR, v);
        check_val("reset iir", 32'(IIR_NONE), v);
        check_val("reset irq", 32'd0, {31'd0, irq});
        apb_read(12'h020, v);
        check_val("unmapped read slverr", 32'd1, {31'd0, last_slverr});
        apb_write(12'h018, 32'h7FF);
        check_val("unmapped write slverr", 32'd1, {31'd0, last_slverr});
        apb_read(`UART_ADDR_LCR, v);
        check_val("lcr after unmapped write", 32'h003, v);
        apb_write(`UART_ADDR_LCR, 32'h035);
        apb_read(`UART_ADDR_LCR, v);
        check_val("lcr readback", 32'h035, v);
        apb_write(`UART_ADDR_LCR, 32'h003);
    endtask

    task automatic test_tx_framing();
        logic [7:0]  b;
        logic [7:0]  exp;
        logic [7:0]  got;
        logic [1:0]  stop_b;
        logic [31:0] v;
        logic        start_b;
        logic        par_b;
        bit          found;
        string       name;
        for (int db = 0; db < 4; db++) begin
            for (int ts = 0; ts < 2; ts++) begin
                for (int pm = 0; pm < 3; pm++) begin
                    name = $sformatf("tx_framing db%0d ts%0d pm%0d", db, ts, pm);
                    apb_write(`UART_ADDR_LCR,
                              lcr_word(db, ts != 0, pm != 0, pm == 2, 0, 1'b1, 1'b0));
                    rand_byte(b);
                    exp = b & 8'((1 << (db + 5)) - 1);
                    apb_write(`UART_ADDR_TDR, {24'd0, b});
                    capture_frame(db + 5, pm != 0, ts != 0, found, start_b, got, par_b, stop_b);
                    if (!found) begin
                        $display("no start bit seen on uart_tx_o in %s", name);
                        timeout_cnt++;
                    end else begin
                        check_val({name, " start"}, 32'd0, {31'd0, start_b});
                        check_val({name, " data"}, {24'd0, exp}, {24'd0, got});
                        if (pm != 0)
                            check_val({name, " parity"}, {31'd0, (pm == 2) ? ~^exp : ^exp},
                                      {31'd0, par_b});
                        check_val({name, " stop"}, 32'd3, {30'd0, stop_b});
                    end
                    wait_lsr(32'h10, name, v);
                end
            end
        end
    endtask

    task automatic test_tx_overrun();
        logic [7:0]  b;
        logic [7:0]  got;
        logic [1:0]  stop_b;
        logic [31:0] v;
        logic        start_b;
        logic        par_b;
        bit          found;
        int          lows;
        apb_write(`UART_ADDR_LCR, lcr_word(3, 1'b0, 1'b0, 1'b0, 0, 1'b1, 1'b0));
        rand_byte(b);
        apb_write(`UART_ADDR_TDR, {24'd0, b});
        apb_write(`UART_ADDR_TDR, {24'd0, ~b});
        apb_read(`UART_ADDR_LSR, v);
        check_val("tx_overrun lsr", 32'h20, v);
        capture_frame(8, 1'b0, 1'b0, found, start_b, got, par_b, stop_b);
        if (!found) begin
            $display("no start bit seen on uart_tx_o in tx_overrun");
            timeout_cnt++;
        end
        check_val("tx_overrun data", {24'd0, b}, {24'd0, got});
        wait_lsr(32'h10, "tx_overrun", v);
        // second byte must never go out
        lows = 0;
        repeat (2 * FRAME_BITS * BIT_CLKS) begin
            @(negedge clk);
            if (!uart_tx) lows++;
        end
        check_val("tx_overrun quiet line", 32'd0, 32'(lows));
        apb_read(`UART_ADDR_TDR, v);
        check_val("tx_overrun tdr", {24'd0, b}, v);
        apb_read(`UART_ADDR_LSR, v);
        check_val("tx_overrun lsr cleared", 32'h10, v);
    endtask

    task automatic rx_case(input string name, input int db, input bit ts, input bit pe,
                           input bit po, input bit bad_par, input bit bad_stop,
                           input logic [31:0] exp_lsr);
        logic [7:0]  b;
        logic [7:0]  exp;
        logic [31:0] v;
        apb_write(`UART_ADDR_LCR, lcr_word(db, ts, pe, po, 0, 1'b0, 1'b1));
        rand_byte(b);
        exp = b & 8'((1 << (db + 5)) - 1);
        send_frame(exp, db + 5, pe, po, ts, bad_par, bad_stop);
        wait_lsr(32'h01, name, v);
        check_val({name, " lsr"}, exp_lsr, v);
        apb_read(`UART_ADDR_LSR, v);
        check_val({name, " lsr after read"}, 32'h11, v);
        apb_read(`UART_ADDR_RDR, v);
        check_val({name, " rdr"}, {24'd0, exp}, v);
        apb_read(`UART_ADDR_LSR, v);
        check_val({name, " lsr after rdr"}, 32'h10, v);
    endtask

    task automatic test_rx_overrun();
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [31:0] v;
        apb_write(`UART_ADDR_LCR, lcr_word(3, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b1));
        rand_byte(b1);
        rand_byte(b2);
        send_frame(b1, 8, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        send_frame(b2, 8, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        apb_read(`UART_ADDR_LSR, v);
        check_val("rx_overrun lsr", 32'h13, v);
        apb_read(`UART_ADDR_RDR, v);
        check_val("rx_overrun rdr", {24'd0, b2}, v);
        apb_read(`UART_ADDR_LSR, v);
        check_val("rx_overrun lsr cleared", 32'h10, v);
    endtask

    task automatic test_interrupts();
        logic [7:0]  b;
        logic [31:0] v;
        apb_write(`UART_ADDR_LCR, lcr_word(3, 1'b0, 1'b1, 1'b0, 0, 1'b0, 1'b1));
        apb_write(`UART_ADDR_IER, 32'h7);
        apb_read(`UART_ADDR_IIR, v);
        check_val("irq idle iir", 32'(IIR_TX_EMPTY), v);
        check_val("irq idle irq", 32'd1, {31'd0, irq});
        rand_byte(b);
        send_frame(b, 8, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_iir(IIR_LINE, "interrupts");
        check_val("irq line irq", 32'd1, {31'd0, irq});
        apb_read(`UART_ADDR_LSR, v);
        check_val("irq line lsr", 32'h15, v);
        apb_read(`UART_ADDR_IIR, v);
        check_val("irq rx ready iir", 32'(IIR_RX_READY), v);
        check_val("irq rx ready irq", 32'd1, {31'd0, irq});
        apb_read(`UART_ADDR_RDR, v);
        check_val("irq rdr", {24'd0, b}, v);
        apb_read(`UART_ADDR_IIR, v);
        check_val("irq tx empty iir", 32'(IIR_TX_EMPTY), v);
        apb_write(`UART_ADDR_IER, 32'h0);
        apb_read(`UART_ADDR_IIR, v);
        check_val("irq none iir", 32'(IIR_NONE), v);
        check_val("irq none irq", 32'd0, {31'd0, irq});
    endtask

    task automatic test_baud_sel();
        logic [31:0] v;
        int          n;
        int          low_clks;
        int          high_clks;
        apb_write(`UART_ADDR_LCR, lcr_word(3, 1'b0, 1'b0, 1'b0, 3, 1'b1, 1'b0));
        // 0x55 puts a high bit right after the start bit
        apb_write(`UART_ADDR_TDR, 32'h55);
        n = 0;
        while (uart_tx && n < 4 * MAX_BIT_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (uart_tx) begin
            $display("no start bit seen on uart_tx_o at baud select 3");
            timeout_cnt++;
        end else begin
            low_clks = 0;
            while (!uart_tx && low_clks < 2 * MAX_BIT_CLKS) begin
                low_clks++;
                @(negedge clk);
            end
            high_clks = 0;
            while (uart_tx && high_clks < 2 * MAX_BIT_CLKS) begin
                high_clks++;
                @(negedge clk);
            end
            check_val("baud_sel start bit", 32'(16 * `UART_BASE_DIV * 8), 32'(low_clks));
            check_val("baud_sel data bit", 32'(16 * `UART_BASE_DIV * 8), 32'(high_clks));
        end
        wait_lsr(32'h10, "baud_sel", v);
        apb_write(`UART_ADDR_LCR, 32'h003);
    endtask

    initial begin
        preset_n    = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 12'h000;
        pwdata      = 32'd0;
        uart_rx     = 1'b1;
        last_slverr = 1'b0;
        check_cnt   = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        repeat (5) @(posedge clk);
        preset_n <= 1'b1;
        repeat (2) @(posedge clk);

        test_reset_decode();
        test_tx_framing();
        rx_case("rx 8e1", 3, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h11);
        rx_case("rx 5o2", 0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 32'h11);
        rx_case("rx 6n1", 1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h11);
        rx_case("rx bad parity", 3, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 32'h15);
        rx_case("rx bad stop", 3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h19);
        test_rx_overrun();
        test_tx_overrun();
        test_interrupts();
        test_baud_sel();

        $display("checks %0d, mismatches %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: apb_uart.f
+incdir+hdl
hdl/uart_cfg_pkg.sv
hdl/uart_status_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_tx_fsm.sv
hdl/uart_rx_shift.sv
hdl/apb_uart_regs.sv
hdl/apb_uart.sv
tb/tb_apb_uart.sv

// File: run_sim.sh
#!/bin/sh
# build and run the APB UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f apb_uart.f --top-module tb_apb_uart -o sim_apb_uart
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_apb_uart)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
